// ==== rtl/logical_layer_config.svh ====
`ifndef LOGICAL_LAYER_CONFIG_SVH
`define LOGICAL_LAYER_CONFIG_SVH

// length of the training burst in local_clk cycles
`define LL_TRAIN_CYCLES 16

// unscrambled training symbol sent on both lanes
`define LL_TS_SYMBOL 8'h4B

// lfsr seeds, one per lane
`define LL_SCR_SEED_L0 16'hFFFF
`define LL_SCR_SEED_L1 16'hACE1

// feedback taps for x^16 + x^5 + x^4 + x^3 + 1
// the x^16 term is the bit shifted out of bit 15
`define LL_SCR_POLY 16'h0039

`endif

// ==== rtl/ll_pkg.sv ====
`default_nettype none

package ll_pkg;

	// link bring-up states
	// encoding is visible in the status register bits 1:0
	typedef enum logic [1:0] {
		// held in reset or by a disable
		LINK_DISABLED     = 2'd0,
		// sbtx high, waiting on sbrx
		LINK_SB_HANDSHAKE = 2'd1,
		// fixed-length training burst on both lanes
		LINK_TRAIN        = 2'd2,
		// active state, transport data allowed
		LINK_CL0          = 2'd3
	} link_state_e;

	// configuration space word addresses
	typedef enum logic [7:0] {
		// bit 0 sw lane disable, bit 1 scrambling enable
		CFG_CONTROL  = 8'h00,
		// link state and sbrx level
		CFG_STATUS   = 8'h04,
		// words accepted on transmit in CL0
		CFG_TX_COUNT = 8'h08,
		// words delivered on receive in CL0
		CFG_RX_COUNT = 8'h0C
	} cfg_addr_e;

	// one symbol on one lane
	typedef logic [7:0] lane_byte_t;

endpackage

`default_nettype wire

// ==== rtl/link_ctrl_if.sv ====
`default_nettype none

interface link_ctrl_if;

	// lanes carry the training symbol
	logic training;
	// transport data allowed
	logic cl0;
	// scrambling active on both datapaths
	logic scr_enable;
	// one-cycle pulse on CL0 entry, reseeds every lfsr
	logic scr_reload;

	// driven by the bring-up FSM
	modport ctrl (output training, output cl0, output scr_enable, output scr_reload);

	// transmit datapath
	modport tx (input training, input cl0, input scr_enable, input scr_reload);

	// receive datapath, no training insertion here
	modport rx (input cl0, input scr_enable, input scr_reload);

endinterface

`default_nettype wire

// ==== rtl/link_ctrl.sv ====
`default_nettype none

`include "logical_layer_config.svh"

module link_ctrl (
	input  logic                local_clk,
	input  logic                arst_n,
	input  logic                lane_disable,
	input  logic                sw_lane_disable,
	input  logic                scr_allow,
	input  logic                sbrx,
	output logic                sbtx,
	output ll_pkg::link_state_e state,
	link_ctrl_if.ctrl           ctl
);

	// counter wide enough for the training length
	localparam int CNT_W = ($clog2(`LL_TRAIN_CYCLES) > 0) ? $clog2(`LL_TRAIN_CYCLES) : 1;

	ll_pkg::link_state_e state_d;
	logic [CNT_W-1:0]    train_cnt;
	logic                train_done;
	logic                disable_any;
	logic                cl0_q;

	// hardware pin or software bit
	assign disable_any = lane_disable | sw_lane_disable;

	// last cycle of the burst
	assign train_done = (train_cnt == CNT_W'(`LL_TRAIN_CYCLES - 1));

	always_comb begin
		state_d = state;
		case (state)
			ll_pkg::LINK_DISABLED: begin
				state_d = ll_pkg::LINK_SB_HANDSHAKE;
			end
			ll_pkg::LINK_SB_HANDSHAKE: begin
				// partner answered on the sideband
				if (sbrx) begin
					state_d = ll_pkg::LINK_TRAIN;
				end
			end
			ll_pkg::LINK_TRAIN: begin
				if (train_done) begin
					state_d = ll_pkg::LINK_CL0;
				end
			end
			default: begin
				// CL0 held until a disable
				state_d = ll_pkg::LINK_CL0;
			end
		endcase
		// disable wins from any state
		if (disable_any) begin
			state_d = ll_pkg::LINK_DISABLED;
		end
	end

	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= ll_pkg::LINK_DISABLED;
			train_cnt <= '0;
			cl0_q     <= 1'b0;
		end else begin
			state <= state_d;
			// counts only inside the burst, zero on entry
			if (state == ll_pkg::LINK_TRAIN) begin
				train_cnt <= train_cnt + 1'b1;
			end else begin
				train_cnt <= '0;
			end
			cl0_q <= ctl.cl0;
		end
	end

	// sideband request only during the handshake
	assign sbtx = (state == ll_pkg::LINK_SB_HANDSHAKE);

	assign ctl.training   = (state == ll_pkg::LINK_TRAIN);
	assign ctl.cl0        = (state == ll_pkg::LINK_CL0);
	assign ctl.scr_enable = ctl.cl0 & scr_allow;
	// first CL0 cycle
	assign ctl.scr_reload = ctl.cl0 & ~cl0_q;

endmodule

`default_nettype wire

// ==== rtl/lane_scrambler.sv ====
`default_nettype none

`include "logical_layer_config.svh"

module lane_scrambler #(
	parameter logic [15:0] SEED = `LL_SCR_SEED_L0
) (
	input  logic               local_clk,
	input  logic               arst_n,
	input  logic               reload,
	input  logic               advance,
	input  logic               bypass,
	input  ll_pkg::lane_byte_t data_in,
	output ll_pkg::lane_byte_t data_out
);

	logic [15:0] lfsr_q;

	// galois lfsr, eight shifts per lane byte
	function automatic logic [15:0] lfsr_next(input logic [15:0] cur);
		logic [15:0] v;
		v = cur;
		for (int i = 0; i < 8; i++) begin
			// bit leaving bit 15 feeds the taps
			v = {v[14:0], 1'b0} ^ (v[15] ? `LL_SCR_POLY : 16'h0000);
		end
		return v;
	endfunction

	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr_q <= SEED;
		end else if (reload) begin
			lfsr_q <= SEED;
		end else if (advance) begin
			lfsr_q <= lfsr_next(lfsr_q);
		end
	end

	// key is the upper byte before the advance
	assign data_out = bypass ? data_in : (data_in ^ lfsr_q[15:8]);

endmodule

`default_nettype wire

// ==== rtl/tx_lane_striper.sv ====
`default_nettype none

`include "logical_layer_config.svh"

module tx_lane_striper (
	input  logic               local_clk,
	input  logic               arst_n,
	link_ctrl_if.tx            ctl,
	input  logic [15:0]        transport_layer_data_in,
	input  logic               transport_valid,
	output ll_pkg::lane_byte_t lane_0_tx_o,
	output ll_pkg::lane_byte_t lane_1_tx_o,
	output logic               lane_tx_valid,
	output logic               tx_word
);

	logic [15:0]        word_q;
	logic               word_vld_q;
	ll_pkg::lane_byte_t scr_l0;
	ll_pkg::lane_byte_t scr_l1;

	// input stage, words outside CL0 are dropped here
	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			word_vld_q <= 1'b0;
		end else begin
			word_vld_q <= transport_valid & ctl.cl0;
		end
	end

	always_ff @(posedge local_clk) begin
		if (transport_valid) begin
			word_q <= transport_layer_data_in;
		end
	end

	// low byte on lane 0
	lane_scrambler #(
		.SEED(`LL_SCR_SEED_L0)
	) i_scr_l0 (
		.local_clk(local_clk),
		.arst_n   (arst_n),
		.reload   (ctl.scr_reload),
		.advance  (word_vld_q),
		.bypass   (~ctl.scr_enable),
		.data_in  (word_q[7:0]),
		.data_out (scr_l0)
	);

	// high byte on lane 1
	lane_scrambler #(
		.SEED(`LL_SCR_SEED_L1)
	) i_scr_l1 (
		.local_clk(local_clk),
		.arst_n   (arst_n),
		.reload   (ctl.scr_reload),
		.advance  (word_vld_q),
		.bypass   (~ctl.scr_enable),
		.data_in  (word_q[15:8]),
		.data_out (scr_l1)
	);

	// lane output stage
	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			lane_tx_valid <= 1'b0;
		end else begin
			lane_tx_valid <= word_vld_q | ctl.training;
		end
	end

	always_ff @(posedge local_clk) begin
		if (word_vld_q) begin
			lane_0_tx_o <= scr_l0;
			lane_1_tx_o <= scr_l1;
		end else if (ctl.training) begin
			// training symbol goes out unscrambled
			lane_0_tx_o <= `LL_TS_SYMBOL;
			lane_1_tx_o <= `LL_TS_SYMBOL;
		end
	end

	// one pulse per accepted word
	assign tx_word = word_vld_q;

endmodule

`default_nettype wire

// ==== rtl/rx_lane_merger.sv ====
`default_nettype none

`include "logical_layer_config.svh"

module rx_lane_merger (
	input  logic               local_clk,
	input  logic               arst_n,
	link_ctrl_if.rx            ctl,
	input  ll_pkg::lane_byte_t lane_0_rx_i,
	input  ll_pkg::lane_byte_t lane_1_rx_i,
	input  logic               enable_deser,
	output logic [15:0]        transport_layer_data_out,
	output logic               transport_data_flag,
	output logic               rx_word
);

	ll_pkg::lane_byte_t lane_0_q;
	ll_pkg::lane_byte_t lane_1_q;
	logic               lanes_vld_q;
	ll_pkg::lane_byte_t dscr_l0;
	ll_pkg::lane_byte_t dscr_l1;

	// input stage
	// first CL0 cycle still carries the trailing training symbol
	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			lanes_vld_q <= 1'b0;
		end else begin
			lanes_vld_q <= enable_deser & ctl.cl0 & ~ctl.scr_reload;
		end
	end

	always_ff @(posedge local_clk) begin
		if (enable_deser) begin
			lane_0_q <= lane_0_rx_i;
			lane_1_q <= lane_1_rx_i;
		end
	end

	// additive scrambling, same lfsr undoes it
	lane_scrambler #(
		.SEED(`LL_SCR_SEED_L0)
	) i_dscr_l0 (
		.local_clk(local_clk),
		.arst_n   (arst_n),
		.reload   (ctl.scr_reload),
		.advance  (lanes_vld_q),
		.bypass   (~ctl.scr_enable),
		.data_in  (lane_0_q),
		.data_out (dscr_l0)
	);

	lane_scrambler #(
		.SEED(`LL_SCR_SEED_L1)
	) i_dscr_l1 (
		.local_clk(local_clk),
		.arst_n   (arst_n),
		.reload   (ctl.scr_reload),
		.advance  (lanes_vld_q),
		.bypass   (~ctl.scr_enable),
		.data_in  (lane_1_q),
		.data_out (dscr_l1)
	);

	// word output stage
	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			transport_data_flag <= 1'b0;
		end else begin
			transport_data_flag <= lanes_vld_q;
		end
	end

	always_ff @(posedge local_clk) begin
		if (lanes_vld_q) begin
			// lane 1 carries the high byte
			transport_layer_data_out <= {dscr_l1, dscr_l0};
		end
	end

	// one pulse per delivered word
	assign rx_word = lanes_vld_q;

endmodule

`default_nettype wire

// ==== rtl/config_space.sv ====
`default_nettype none

module config_space (
	input  logic                local_clk,
	input  logic                arst_n,
	input  logic                c_read,
	input  logic                c_write,
	input  logic [7:0]          c_address,
	input  logic [31:0]         c_data_in,
	output logic [31:0]         c_data_out,
	input  ll_pkg::link_state_e state,
	input  logic                sbrx,
	input  logic                tx_word,
	input  logic                rx_word,
	output logic                sw_lane_disable,
	output logic                scr_allow
);

	logic [1:0]  ctrl_q;
	logic [31:0] tx_cnt;
	logic [31:0] rx_cnt;
	logic [31:0] rd_data;

	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			// scrambling on, lanes enabled
			ctrl_q <= 2'b10;
			tx_cnt <= '0;
			rx_cnt <= '0;
		end else begin
			if (c_write && (c_address == ll_pkg::CFG_CONTROL)) begin
				ctrl_q <= c_data_in[1:0];
			end
			// any write to a counter clears it
			if (c_write && (c_address == ll_pkg::CFG_TX_COUNT)) begin
				tx_cnt <= '0;
			end else if (tx_word) begin
				tx_cnt <= tx_cnt + 32'd1;
			end
			if (c_write && (c_address == ll_pkg::CFG_RX_COUNT)) begin
				rx_cnt <= '0;
			end else if (rx_word) begin
				rx_cnt <= rx_cnt + 32'd1;
			end
		end
	end

	// read mux, unknown addresses give zero
	always_comb begin
		case (c_address)
			ll_pkg::CFG_CONTROL:  rd_data = {30'd0, ctrl_q};
			ll_pkg::CFG_STATUS:   rd_data = {29'd0, sbrx, state};
			ll_pkg::CFG_TX_COUNT: rd_data = tx_cnt;
			ll_pkg::CFG_RX_COUNT: rd_data = rx_cnt;
			default:              rd_data = 32'd0;
		endcase
	end

	// read data one cycle after the strobe
	always_ff @(posedge local_clk or negedge arst_n) begin
		if (!arst_n) begin
			c_data_out <= '0;
		end else if (c_read) begin
			c_data_out <= rd_data;
		end
	end

	assign sw_lane_disable = ctrl_q[0];
	assign scr_allow       = ctrl_q[1];

endmodule

`default_nettype wire

// ==== rtl/logical_layer.sv ====
`default_nettype none

module logical_layer (
	input  logic               local_clk,
	input  logic               arst_n,
	input  logic               lane_disable,
	input  logic               c_read,
	input  logic               c_write,
	input  logic [7:0]         c_address,
	input  logic [31:0]        c_data_in,
	output logic [31:0]        c_data_out,
	input  logic [15:0]        transport_layer_data_in,
	input  logic               transport_valid,
	output logic [15:0]        transport_layer_data_out,
	output logic               transport_data_flag,
	input  ll_pkg::lane_byte_t lane_0_rx_i,
	input  ll_pkg::lane_byte_t lane_1_rx_i,
	input  logic               enable_deser,
	input  logic               sbrx,
	output logic               sbtx,
	output ll_pkg::lane_byte_t lane_0_tx_o,
	output ll_pkg::lane_byte_t lane_1_tx_o,
	output logic               lane_tx_valid,
	output logic               enable_scr,
	output logic               cl0_s
);

	ll_pkg::link_state_e state;
	logic                sw_lane_disable;
	logic                scr_allow;
	logic                tx_word;
	logic                rx_word;

	// control levels from the FSM to both lanes
	link_ctrl_if ctl_if ();

	link_ctrl i_link_ctrl (
		.local_clk      (local_clk),
		.arst_n         (arst_n),
		.lane_disable   (lane_disable),
		.sw_lane_disable(sw_lane_disable),
		.scr_allow      (scr_allow),
		.sbrx           (sbrx),
		.sbtx           (sbtx),
		.state          (state),
		.ctl            (ctl_if.ctrl)
	);

	tx_lane_striper i_tx_lane_striper (
		.local_clk              (local_clk),
		.arst_n                 (arst_n),
		.ctl                    (ctl_if.tx),
		.transport_layer_data_in(transport_layer_data_in),
		.transport_valid        (transport_valid),
		.lane_0_tx_o            (lane_0_tx_o),
		.lane_1_tx_o            (lane_1_tx_o),
		.lane_tx_valid          (lane_tx_valid),
		.tx_word                (tx_word)
	);

	rx_lane_merger i_rx_lane_merger (
		.local_clk               (local_clk),
		.arst_n                  (arst_n),
		.ctl                     (ctl_if.rx),
		.lane_0_rx_i             (lane_0_rx_i),
		.lane_1_rx_i             (lane_1_rx_i),
		.enable_deser            (enable_deser),
		.transport_layer_data_out(transport_layer_data_out),
		.transport_data_flag     (transport_data_flag),
		.rx_word                 (rx_word)
	);

	config_space i_config_space (
		.local_clk      (local_clk),
		.arst_n         (arst_n),
		.c_read         (c_read),
		.c_write        (c_write),
		.c_address      (c_address),
		.c_data_in      (c_data_in),
		.c_data_out     (c_data_out),
		.state          (state),
		.sbrx           (sbrx),
		.tx_word        (tx_word),
		.rx_word        (rx_word),
		.sw_lane_disable(sw_lane_disable),
		.scr_allow      (scr_allow)
	);

	// link status straight from the FSM levels
	assign cl0_s      = ctl_if.cl0;
	assign enable_scr = ctl_if.scr_enable;

endmodule

`default_nettype wire

// ==== verif/tb_logical_layer.sv ====
`default_nettype none

`include "logical_layer_config.svh"

module tb_logical_layer;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 5;
	localparam int TX_WORDS     = 24;
	// reset, handshake, three trainings, five bursts of up to four cycles per word
	// config accesses and dropped traffic fit in the margin
	localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + 40 + 3 * (`LL_TRAIN_CYCLES + 30)
		+ 5 * TX_WORDS * 4 + 120);

	logic               local_clk = 1'b0;
	logic               arst_n;
	logic               lane_disable;
	logic               c_read;
	logic               c_write;
	logic [7:0]         c_address;
	logic [31:0]        c_data_in;
	logic [31:0]        c_data_out;
	logic [15:0]        transport_layer_data_in;
	logic               transport_valid;
	logic [15:0]        transport_layer_data_out;
	logic               transport_data_flag;
	ll_pkg::lane_byte_t lane_0_rx_i;
	ll_pkg::lane_byte_t lane_1_rx_i;
	logic               enable_deser;
	logic               sbrx;
	logic               sbtx;
	ll_pkg::lane_byte_t lane_0_tx_o;
	ll_pkg::lane_byte_t lane_1_tx_o;
	logic               lane_tx_valid;
	logic               enable_scr;
	logic               cl0_s;

	// rx side driven directly when loopback is off
	logic               loopback;
	ll_pkg::lane_byte_t lane_0_rx_drv;
	ll_pkg::lane_byte_t lane_1_rx_drv;
	logic               deser_drv;

	// scrambler model with one lfsr per lane
	logic [15:0]        lfsr_l0;
	logic [15:0]        lfsr_l1;
	logic               scr_on;

	// words still expected on the receive side
	logic [15:0]        rx_exp[$];
	logic [15:0]        rx_exp_word;
	int                 cycle_cnt = 0;

	always #20 local_clk = ~local_clk;

	// combinational loopback channel from tx lanes to rx lanes
	assign lane_0_rx_i  = loopback ? lane_0_tx_o : lane_0_rx_drv;
	assign lane_1_rx_i  = loopback ? lane_1_tx_o : lane_1_rx_drv;
	assign enable_deser = loopback ? lane_tx_valid : deser_drv;

	logical_layer i_logical_layer (
		.local_clk               (local_clk),
		.arst_n                  (arst_n),
		.lane_disable            (lane_disable),
		.c_read                  (c_read),
		.c_write                 (c_write),
		.c_address               (c_address),
		.c_data_in               (c_data_in),
		.c_data_out              (c_data_out),
		.transport_layer_data_in (transport_layer_data_in),
		.transport_valid         (transport_valid),
		.transport_layer_data_out(transport_layer_data_out),
		.transport_data_flag     (transport_data_flag),
		.lane_0_rx_i             (lane_0_rx_i),
		.lane_1_rx_i             (lane_1_rx_i),
		.enable_deser            (enable_deser),
		.sbrx                    (sbrx),
		.sbtx                    (sbtx),
		.lane_0_tx_o             (lane_0_tx_o),
		.lane_1_tx_o             (lane_1_tx_o),
		.lane_tx_valid           (lane_tx_valid),
		.enable_scr              (enable_scr),
		.cl0_s                   (cl0_s)
	);

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	// galois register where the x^16 term folds back into the taps
	function automatic logic [15:0] model_advance(input logic [15:0] s);
		logic [15:0] v;
		v = s;
		for (int i = 0; i < 8; i++) begin
			if (v[15]) begin
				v = (v << 1) ^ `LL_SCR_POLY;
			end else begin
				v = v << 1;
			end
		end
		return v;
	endfunction

	// hang guard
	always @(posedge local_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < CYCLE_LIMIT) else
			fail_with("run exceeded its cycle limit, the DUT stopped responding");
	end

	// receive monitor expects words back in send order
	always @(negedge local_clk) begin
		if (arst_n && transport_data_flag) begin
			assert (rx_exp.size() != 0) else
				fail_with("received a word while none was outstanding");
			rx_exp_word = rx_exp.pop_front();
			check_value("transport_layer_data_out", transport_layer_data_out, rx_exp_word);
		end
	end

	task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge local_clk);
		c_write   <= 1'b1;
		c_address <= addr;
		c_data_in <= data;
		@(posedge local_clk);
		c_write   <= 1'b0;
	endtask

	// read data registered on the edge after the strobe
	task automatic cfg_read_check(input logic [7:0] addr, input logic [31:0] exp,
		input string name);
		@(posedge local_clk);
		c_read    <= 1'b1;
		c_address <= addr;
		@(posedge local_clk);
		c_read    <= 1'b0;
		@(negedge local_clk);
		check_value(name, c_data_out, exp);
	endtask

	// random words with random gaps and lanes checked two edges after drive
	task automatic send_words(input int n, input int max_gap);
		logic        pipe_vld [2];
		logic [7:0]  pipe_l0 [2];
		logic [7:0]  pipe_l1 [2];
		logic [15:0] w;
		int          words_left;
		int          idle;
		pipe_vld = '{1'b0, 1'b0};
		pipe_l0  = '{8'h00, 8'h00};
		pipe_l1  = '{8'h00, 8'h00};
		words_left = n;
		idle = 0;
		while (words_left > 0 || pipe_vld[0] || pipe_vld[1]) begin
			@(posedge local_clk);
			if (words_left > 0 && idle == 0) begin
				w = 16'($urandom);
				transport_valid         <= 1'b1;
				transport_layer_data_in <= w;
				if (loopback) begin
					rx_exp.push_back(w);
				end
				words_left--;
				idle = $urandom_range(max_gap, 0);
			end else begin
				transport_valid <= 1'b0;
				if (idle > 0) begin
					idle--;
				end
			end
			@(negedge local_clk);
			check_value("lane_tx_valid", lane_tx_valid, pipe_vld[1]);
			check_value("enable_scr", enable_scr, scr_on);
			if (pipe_vld[1]) begin
				check_value("lane_0_tx_o", lane_0_tx_o, pipe_l0[1]);
				check_value("lane_1_tx_o", lane_1_tx_o, pipe_l1[1]);
			end
			pipe_vld[1] = pipe_vld[0];
			pipe_l0[1]  = pipe_l0[0];
			pipe_l1[1]  = pipe_l1[0];
			pipe_vld[0] = transport_valid;
			if (transport_valid) begin
				// key is the upper byte before the step
				pipe_l0[0] = scr_on ? (transport_layer_data_in[7:0] ^ lfsr_l0[15:8])
					: transport_layer_data_in[7:0];
				pipe_l1[0] = scr_on ? (transport_layer_data_in[15:8] ^ lfsr_l1[15:8])
					: transport_layer_data_in[15:8];
				lfsr_l0 = model_advance(lfsr_l0);
				lfsr_l1 = model_advance(lfsr_l1);
			end
		end
	endtask

	// words outside CL0 must not reach the lanes
	task automatic send_dropped(input int n);
		repeat (n) begin
			@(posedge local_clk);
			transport_valid         <= 1'b1;
			transport_layer_data_in <= 16'($urandom);
			@(negedge local_clk);
			check_value("lane_tx_valid", lane_tx_valid, 1'b0);
		end
		@(posedge local_clk);
		transport_valid <= 1'b0;
		repeat (3) begin
			@(negedge local_clk);
			check_value("lane_tx_valid", lane_tx_valid, 1'b0);
		end
	endtask

	// rx lane bytes outside CL0 must not reach the transport side
	task automatic send_rx_dropped(input int n);
		@(posedge local_clk);
		loopback <= 1'b0;
		repeat (n) begin
			@(posedge local_clk);
			deser_drv     <= 1'b1;
			lane_0_rx_drv <= 8'($urandom);
			lane_1_rx_drv <= 8'($urandom);
			@(negedge local_clk);
			check_value("transport_data_flag", transport_data_flag, 1'b0);
		end
		@(posedge local_clk);
		deser_drv <= 1'b0;
		repeat (3) begin
			@(negedge local_clk);
			check_value("transport_data_flag", transport_data_flag, 1'b0);
		end
	endtask

	// raise sbrx and count the training burst
	task automatic run_training(input logic scr_exp);
		int waited;
		int ts_cnt;
		@(posedge local_clk);
		sbrx <= 1'b1;
		waited = 0;
		@(negedge local_clk);
		while (!lane_tx_valid) begin
			waited++;
			assert (waited < 8) else fail_with("training burst did not start after sbrx");
			@(negedge local_clk);
		end
		ts_cnt = 0;
		while (lane_tx_valid) begin
			check_value("lane_0_tx_o", lane_0_tx_o, `LL_TS_SYMBOL);
			check_value("lane_1_tx_o", lane_1_tx_o, `LL_TS_SYMBOL);
			ts_cnt++;
			assert (ts_cnt <= `LL_TRAIN_CYCLES) else fail_with("training burst too long");
			@(negedge local_clk);
		end
		check_value("training burst length", ts_cnt, `LL_TRAIN_CYCLES);
		check_value("cl0_s", cl0_s, 1'b1);
		check_value("enable_scr", enable_scr, scr_exp);
		// both ends reseed on CL0 entry
		lfsr_l0 = `LL_SCR_SEED_L0;
		lfsr_l1 = `LL_SCR_SEED_L1;
		scr_on  = scr_exp;
	endtask

	task automatic wait_rx_drain();
		int waited;
		waited = 0;
		while (rx_exp.size() != 0) begin
			@(posedge local_clk);
			waited++;
			assert (waited < 16) else fail_with("looped back words never arrived");
		end
	endtask

	task automatic test_reset_handshake();
		int waited;
		@(negedge local_clk);
		check_value("sbtx", sbtx, 1'b0);
		check_value("cl0_s", cl0_s, 1'b0);
		check_value("enable_scr", enable_scr, 1'b0);
		check_value("lane_tx_valid", lane_tx_valid, 1'b0);
		check_value("transport_data_flag", transport_data_flag, 1'b0);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h0, "status while disabled");
		cfg_read_check(ll_pkg::CFG_CONTROL, 32'h2, "control reset value");
		@(posedge local_clk);
		lane_disable <= 1'b0;
		waited = 0;
		@(negedge local_clk);
		while (!sbtx) begin
			waited++;
			assert (waited < 4) else fail_with("sbtx did not rise after enabling the lanes");
			@(negedge local_clk);
		end
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h1, "status in handshake");
		send_dropped(4);
		// still waiting on the partner
		check_value("sbtx", sbtx, 1'b1);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h1, "status in handshake");
		cfg_read_check(ll_pkg::CFG_TX_COUNT, 32'h0, "tx count outside CL0");
	endtask

	task automatic test_training();
		run_training(1'b1);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h7, "status in CL0");
	endtask

	task automatic test_scrambled_tx();
		send_words(TX_WORDS, 0);
		send_words(TX_WORDS, 3);
	endtask

	task automatic test_loopback_rx();
		// re-train so both lfsr pairs start together
		cfg_write(ll_pkg::CFG_CONTROL, 32'h3);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h4, "status after sw disable");
		@(posedge local_clk);
		loopback <= 1'b1;
		cfg_write(ll_pkg::CFG_CONTROL, 32'h2);
		run_training(1'b1);
		send_words(TX_WORDS, 0);
		send_words(TX_WORDS, 2);
		wait_rx_drain();
	endtask

	task automatic test_config_space();
		// scrambling off for the next bring-up
		cfg_write(ll_pkg::CFG_CONTROL, 32'h1);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h4, "status after sw disable");
		check_value("enable_scr", enable_scr, 1'b0);
		cfg_write(ll_pkg::CFG_CONTROL, 32'h0);
		run_training(1'b0);
		// any write clears a counter
		cfg_write(ll_pkg::CFG_TX_COUNT, 32'hFFFF_FFFF);
		cfg_write(ll_pkg::CFG_RX_COUNT, 32'h1);
		cfg_read_check(ll_pkg::CFG_TX_COUNT, 32'h0, "tx count after clear");
		send_words(TX_WORDS, 1);
		wait_rx_drain();
		cfg_read_check(ll_pkg::CFG_TX_COUNT, TX_WORDS, "tx count");
		cfg_read_check(ll_pkg::CFG_RX_COUNT, TX_WORDS, "rx count");
		cfg_write(ll_pkg::CFG_CONTROL, 32'h1);
		cfg_read_check(ll_pkg::CFG_STATUS, 32'h4, "status after sw disable");
		check_value("cl0_s", cl0_s, 1'b0);
		send_dropped(5);
		send_rx_dropped(5);
		cfg_read_check(ll_pkg::CFG_TX_COUNT, TX_WORDS, "tx count after dropped words");
		cfg_read_check(ll_pkg::CFG_RX_COUNT, TX_WORDS, "rx count after dropped words");
	endtask

	initial begin
		void'($urandom(16518));
		arst_n                  = 1'b0;
		lane_disable            = 1'b1;
		c_read                  = 1'b0;
		c_write                 = 1'b0;
		c_address               = 8'h00;
		c_data_in               = 32'h0;
		transport_layer_data_in = 16'h0;
		transport_valid         = 1'b0;
		sbrx                    = 1'b0;
		loopback                = 1'b0;
		lane_0_rx_drv           = 8'h00;
		lane_1_rx_drv           = 8'h00;
		deser_drv               = 1'b0;
		lfsr_l0                 = `LL_SCR_SEED_L0;
		lfsr_l1                 = `LL_SCR_SEED_L1;
		scr_on                  = 1'b1;
		repeat (RESET_CYCLES) @(posedge local_clk);
		arst_n <= 1'b1;
		test_reset_handshake();
		test_training();
		test_scrambled_tx();
		test_loopback_rx();
		test_config_space();
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/ll_pkg.sv
rtl/link_ctrl_if.sv
rtl/link_ctrl.sv
rtl/lane_scrambler.sv
rtl/tx_lane_striper.sv
rtl/rx_lane_merger.sv
rtl/config_space.sv
rtl/logical_layer.sv
verif/tb_logical_layer.sv

// ==== Bender.yml ====
package:
  name: logical_layer

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ll_pkg.sv
      - rtl/link_ctrl_if.sv
      - rtl/link_ctrl.sv
      - rtl/lane_scrambler.sv
      - rtl/tx_lane_striper.sv
      - rtl/rx_lane_merger.sv
      - rtl/config_space.sv
      - rtl/logical_layer.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_logical_layer.sv
